//--- logic/radiant_pkg.sv
package radiant_pkg;

    // digitizer channels on this board
    localparam int NUM_CH = 4;
    // bits per digitized sample
    localparam int SAMPLE_W = 12;
    // tag bits placed above each sample
    localparam int HEADER_W = 4;
    // one buffered word, header on top
    localparam int WORD_W = HEADER_W + SAMPLE_W;
    // samples per channel in one event
    localparam int SAMPLES_PER_EVENT = 8;
    // buffer holds two full events
    localparam int FIFO_DEPTH = 64;

    // set bit means that data line is inverted, channel 0 is the lsb
    localparam logic [NUM_CH-1:0] DOE_POLARITY = 4'b1001;
    // header bits replaced by the rolling event counter
    localparam logic [HEADER_W-1:0] HEADER_COUNTER_MASK = 4'b1100;

    // index widths for the readout counters
    localparam int BIT_IDX_W = $clog2(SAMPLE_W);
    localparam int SMP_IDX_W = $clog2(SAMPLES_PER_EVENT);
    localparam int CH_IDX_W = $clog2(NUM_CH);
    // buffer address width, depth is a power of two
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [HEADER_W-1:0] header_t;
    // header in [15:12], sample in [11:0]
    typedef logic [WORD_W-1:0] lab_word_t;
    typedef logic [NUM_CH-1:0] chan_mask_t;
    // occupancy, needs to reach FIFO_DEPTH itself
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_ptr_t;

    // producer sequencing
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        WRITE
    } readout_state_t;

endpackage

//--- logic/lab_wr_if.sv
`timescale 1ns/1ns

interface lab_wr_if;
    import radiant_pkg::*;

    // word offered this cycle
    logic      wr_en;
    // tagged, polarity-corrected sample
    lab_word_t wr_dat;
    // final word of the event
    logic      wr_last;
    // buffer at capacity, offered words are lost
    logic      full;

    // producer never looks at full, a digitizer cannot stall
    modport producer (
        output wr_en,
        output wr_dat,
        output wr_last
    );

    modport buffer (
        input  wr_en,
        input  wr_dat,
        input  wr_last,
        output full
    );

endinterface

//--- logic/fifo_rd_if.sv
`timescale 1ns/1ns

interface fifo_rd_if;
    import radiant_pkg::*;

    // pop request, only while not empty
    logic      rd_en;
    // registered read data, valid the cycle after the pop
    lab_word_t rd_dat;
    // last flag travelling with rd_dat
    logic      rd_last;
    // nothing stored
    logic      empty;

    modport buffer (
        input  rd_en,
        output rd_dat,
        output rd_last,
        output empty
    );

    modport consumer (
        output rd_en,
        input  rd_dat,
        input  rd_last,
        input  empty
    );

endinterface

//--- logic/lab_readout.sv
`timescale 1ns/1ns

module lab_readout (
    input  logic                 sysclk,
    input  logic                 arst_n_i,
    input  logic                 readout_i,
    input  radiant_pkg::header_t readout_header_i,
    input  radiant_pkg::chan_mask_t doe_i,
    lab_wr_if.producer           wr,
    output logic                 complete_o
);
    import radiant_pkg::*;

    // sequencing state
    readout_state_t         state;
    // bit within the sample being shifted, msb first
    logic [BIT_IDX_W-1:0]   bit_idx;
    // sample number within the event
    logic [SMP_IDX_W-1:0]   smp_idx;
    // channel being written
    logic [CH_IDX_W-1:0]    ch_idx;
    // rolling event counter, advances on every accepted start
    header_t                evt_cnt;
    logic                   complete_q;

    // per-channel shift registers
    sample_t                sample_q [NUM_CH];
    // header of the running event, counter bits already merged
    header_t                hdr_q;

    logic                   start;
    logic                   bit_done;
    logic                   ch_done;
    logic                   smp_done;
    sample_t                sample_fix;

    // merge counter low bits into the masked header positions
    // counter bit 0 lands in the lowest masked bit and so on upward
    function automatic header_t tag_header(header_t hdr_in, header_t cnt);
        header_t res;
        int      j;
        res = hdr_in;
        j = 0;
        for (int i = 0; i < HEADER_W; i++) begin
            if (HEADER_COUNTER_MASK[i]) begin
                res[i] = cnt[j];
                j++;
            end
        end
        return res;
    endfunction

    // readout strobe only counts while idle
    assign start    = (state == IDLE) && readout_i;
    assign bit_done = (bit_idx == BIT_IDX_W'(SAMPLE_W - 1));
    assign ch_done  = (ch_idx == CH_IDX_W'(NUM_CH - 1));
    assign smp_done = (smp_idx == SMP_IDX_W'(SAMPLES_PER_EVENT - 1));

    // control: 12 shift cycles then 4 write cycles per sample
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state      <= IDLE;
            bit_idx    <= '0;
            smp_idx    <= '0;
            ch_idx     <= '0;
            evt_cnt    <= '0;
            complete_q <= 1'b0;
        end else begin
            complete_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= SHIFT;
                        bit_idx <= '0;
                        smp_idx <= '0;
                        evt_cnt <= evt_cnt + 1'b1;
                    end
                end
                SHIFT: begin
                    // last bit shifts on this edge
                    if (bit_done) begin
                        bit_idx <= '0;
                        ch_idx  <= '0;
                        state   <= WRITE;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                WRITE: begin
                    if (ch_done) begin
                        ch_idx <= '0;
                        if (smp_done) begin
                            // event finished, flag it for one cycle
                            state      <= IDLE;
                            complete_q <= 1'b1;
                        end else begin
                            smp_idx <= smp_idx + 1'b1;
                            state   <= SHIFT;
                        end
                    end else begin
                        ch_idx <= ch_idx + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // data path
    always_ff @(posedge sysclk) begin
        if (start) begin
            hdr_q <= tag_header(readout_header_i, evt_cnt);
        end
        // all channels shift together, msb arrives first
        if (state == SHIFT) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                sample_q[ch] <= {sample_q[ch][SAMPLE_W-2:0], doe_i[ch]};
            end
        end
    end

    // undo the line inversion of the selected channel
    assign sample_fix = sample_q[ch_idx] ^ {SAMPLE_W{DOE_POLARITY[ch_idx]}};

    assign wr.wr_en   = (state == WRITE);
    assign wr.wr_dat  = {hdr_q, sample_fix};
    // channel 3 of sample 7
    assign wr.wr_last = (state == WRITE) && ch_done && smp_done;

    assign complete_o = complete_q;

endmodule

//--- logic/event_fifo.sv
`timescale 1ns/1ns

module event_fifo (
    input  logic       sysclk,
    input  logic       arst_n_i,
    lab_wr_if.buffer   wr,
    fifo_rd_if.buffer  rd,
    output logic       full_o,
    output logic       empty_o
);
    import radiant_pkg::*;

    // storage, words and their last flags side by side
    lab_word_t          mem      [FIFO_DEPTH];
    logic               last_mem [FIFO_DEPTH];

    // pointers wrap by themselves since depth is a power of two
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    fifo_ptr_t          count;

    lab_word_t          rd_dat_q;
    logic               rd_last_q;

    logic               full;
    logic               empty;
    logic               do_wr;
    logic               do_rd;

    assign full  = (count == fifo_ptr_t'(FIFO_DEPTH));
    assign empty = (count == '0);

    // writes at full are simply dropped
    assign do_wr = wr.wr_en && !full;
    assign do_rd = rd.rd_en && !empty;

    // pointers and occupancy
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // array write
    always_ff @(posedge sysclk) begin
        if (do_wr) begin
            mem[wr_ptr]      <= wr.wr_dat;
            last_mem[wr_ptr] <= wr.wr_last;
        end
    end

    // registered read data, holds between pops
    always_ff @(posedge sysclk) begin
        if (do_rd) begin
            rd_dat_q <= mem[rd_ptr];
        end
    end

    // last flag cleared on reset so the output starts low
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_last_q <= 1'b0;
        end else if (do_rd) begin
            rd_last_q <= last_mem[rd_ptr];
        end
    end

    assign wr.full    = full;
    assign rd.empty   = empty;
    assign rd.rd_dat  = rd_dat_q;
    assign rd.rd_last = rd_last_q;

    assign full_o  = full;
    assign empty_o = empty;

endmodule

//--- logic/event_sender.sv
`timescale 1ns/1ns

module event_sender (
    input  logic                  sysclk,
    input  logic                  arst_n_i,
    fifo_rd_if.consumer           rd,
    input  logic                  out_rdy_i,
    output radiant_pkg::lab_word_t evt_dat_o,
    output logic                  evt_valid_o,
    output logic                  evt_last_o
);

    // pop issued last cycle, read data now on rd_dat
    logic valid_q;
    logic pop;

    // downstream ready is a level, one pop per cycle at most
    assign pop = out_rdy_i && !rd.empty;

    assign rd.rd_en = pop;

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop;
        end
    end

    // fifo holds its read register, so data line up with valid_q
    assign evt_dat_o   = rd.rd_dat;
    assign evt_valid_o = valid_q;
    // last only means something together with valid
    assign evt_last_o  = valid_q && rd.rd_last;

endmodule

//--- logic/radiant_readout_top.sv
`timescale 1ns/1ns

module radiant_readout_top (
    input  logic                    sysclk,
    input  logic                    arst_n_i,
    input  logic                    readout_i,
    input  radiant_pkg::header_t    readout_header_i,
    input  radiant_pkg::chan_mask_t doe_i,
    input  logic                    out_rdy_i,
    output radiant_pkg::lab_word_t  evt_dat_o,
    output logic                    evt_valid_o,
    output logic                    evt_last_o,
    output logic                    complete_o,
    output logic                    fifo_full_o,
    output logic                    fifo_empty_o
);

    // producer to buffer
    lab_wr_if  u_wr_if ();
    // buffer to consumer
    fifo_rd_if u_rd_if ();

    // serial shift, polarity fix and tagging
    lab_readout u_readout (
        .sysclk           (sysclk),
        .arst_n_i         (arst_n_i),
        .readout_i        (readout_i),
        .readout_header_i (readout_header_i),
        .doe_i            (doe_i),
        .wr               (u_wr_if.producer),
        .complete_o       (complete_o)
    );

    // two-event buffer, drops on full
    event_fifo u_fifo (
        .sysclk   (sysclk),
        .arst_n_i (arst_n_i),
        .wr       (u_wr_if.buffer),
        .rd       (u_rd_if.buffer),
        .full_o   (fifo_full_o),
        .empty_o  (fifo_empty_o)
    );

    // drains while downstream ready
    event_sender u_sender (
        .sysclk      (sysclk),
        .arst_n_i    (arst_n_i),
        .rd          (u_rd_if.consumer),
        .out_rdy_i   (out_rdy_i),
        .evt_dat_o   (evt_dat_o),
        .evt_valid_o (evt_valid_o),
        .evt_last_o  (evt_last_o)
    );

endmodule

//--- test/radiant_readout_asserts.sv
`timescale 1ns/1ns

module radiant_readout_asserts (
    input logic                  sysclk,
    input logic                  arst_n_i,
    input logic                  full_i,
    input logic                  empty_i,
    input logic                  rd_en_i,
    input radiant_pkg::fifo_ptr_t count_i
);
    import radiant_pkg::*;

    // running count of assertion failures
    int unsigned fail_cnt = 0;

    // status flags are exclusive
    a_full_empty: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        !(full_i && empty_i))
    else begin
        fail_cnt++;
        $error("buffer full and empty together");
    end

    // consumer never pops an empty buffer
    a_pop_empty: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        !(rd_en_i && empty_i))
    else begin
        fail_cnt++;
        $error("pop while buffer empty");
    end

    a_occupancy: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        count_i <= fifo_ptr_t'(FIFO_DEPTH))
    else begin
        fail_cnt++;
        $error("buffer occupancy above depth");
    end

endmodule

bind event_fifo radiant_readout_asserts u_asserts (
    .sysclk   (sysclk),
    .arst_n_i (arst_n_i),
    .full_i   (full),
    .empty_i  (empty),
    .rd_en_i  (rd.rd_en),
    .count_i  (count)
);

//--- test/tb_radiant_readout.sv
`timescale 1ns/1ns

module tb_radiant_readout;
    import radiant_pkg::*;

    // 12 shift cycles then 4 write cycles
    localparam int SAMPLE_CYCLES = SAMPLE_W + NUM_CH;
    localparam int EVENT_CYCLES = SAMPLE_CYCLES * SAMPLES_PER_EVENT;
    localparam int NUM_EVENTS = 14;
    // drain allowance for each of the six tests
    localparam int DRAIN_CYCLES = 6 * 4 * FIFO_DEPTH;
    localparam int WATCHDOG_CYCLES = 2 * (NUM_EVENTS * EVENT_CYCLES + DRAIN_CYCLES);
    // out_rdy_i patterns
    localparam int RDY_HIGH = 0;
    localparam int RDY_LOW = 1;
    localparam int RDY_RANDOM = 2;

    logic       sysclk;
    logic       arst_n_i;
    logic       readout_i;
    header_t    readout_header_i;
    chan_mask_t doe_i;
    logic       out_rdy_i;
    lab_word_t  evt_dat_o;
    logic       evt_valid_o;
    logic       evt_last_o;
    logic       complete_o;
    logic       fifo_full_o;
    logic       fifo_empty_o;

    logic [31:0] lfsr_q = 32'd94982;
    int          rdy_mode;
    // word the producer offers on the next edge
    logic        pend_valid;
    lab_word_t   pend_word;
    logic        pend_last;
    // expected output words oldest first
    lab_word_t   exp_dat_q [$];
    logic        exp_last_q [$];
    // modelled buffer occupancy
    int          occ;
    int          evt_num;
    int          cmpl_cnt;
    int          out_cnt;
    logic        full_seen;
    logic        rdy_d;

    radiant_readout_top u_dut (
        .sysclk           (sysclk),
        .arst_n_i         (arst_n_i),
        .readout_i        (readout_i),
        .readout_header_i (readout_header_i),
        .doe_i            (doe_i),
        .out_rdy_i        (out_rdy_i),
        .evt_dat_o        (evt_dat_o),
        .evt_valid_o      (evt_valid_o),
        .evt_last_o       (evt_last_o),
        .complete_o       (complete_o),
        .fifo_full_o      (fifo_full_o),
        .fifo_empty_o     (fifo_empty_o)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function logic rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // expected word with the counter in the masked header bits and inverted lines complemented
    function automatic lab_word_t expected_word(sample_t raw, int ch, header_t hdr_in, int evt);
        header_t hdr;
        sample_t smp;
        hdr = (hdr_in & ~HEADER_COUNTER_MASK) | (header_t'((evt % 4) << 2) & HEADER_COUNTER_MASK);
        smp = DOE_POLARITY[ch] ? ~raw : raw;
        return {hdr, smp};
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // one readout entered and left 5 ns after an edge
    task automatic run_event(input bit busy_pulse);
        header_t    hdr;
        sample_t    raw [NUM_CH];
        chan_mask_t bits;
        hdr = header_t'(rand_bits(HEADER_W));
        readout_i = 1'b1;
        readout_header_i = hdr;
        @(posedge sysclk);
        #5;
        readout_i = 1'b0;
        for (int s = 0; s < SAMPLES_PER_EVENT; s++) begin
            for (int i = 0; i < SAMPLE_CYCLES; i++) begin
                if (i < SAMPLE_W) begin
                    // msb of each channel comes first
                    bits = chan_mask_t'(rand_bits(NUM_CH));
                    doe_i = bits;
                    for (int c = 0; c < NUM_CH; c++) begin
                        raw[c][SAMPLE_W-1-i] = bits[c];
                    end
                    pend_valid = 1'b0;
                end else begin
                    pend_valid = 1'b1;
                    pend_word = expected_word(raw[i-SAMPLE_W], i - SAMPLE_W, hdr, evt_num);
                    pend_last = (s == SAMPLES_PER_EVENT - 1) && (i == SAMPLE_CYCLES - 1);
                end
                // stray strobe in the middle of the event
                if (busy_pulse && s == 3) begin
                    readout_i = (i == 5);
                end
                @(posedge sysclk);
                #5;
            end
        end
        pend_valid = 1'b0;
        evt_num++;
    endtask

    task automatic wait_drain();
        while (occ != 0) begin
            @(posedge sysclk);
            #5;
        end
        // a few idle cycles to catch stray words
        repeat (4) begin
            @(posedge sysclk);
            #5;
        end
    endtask

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // ready level picked at the edge and driven 5 ns later
    initial begin
        logic rdy_nxt;
        forever begin
            @(posedge sysclk);
            case (rdy_mode)
                RDY_LOW:    rdy_nxt = 1'b0;
                RDY_RANDOM: rdy_nxt = rand_bit();
                default:    rdy_nxt = 1'b1;
            endcase
            #5;
            out_rdy_i = rdy_nxt;
        end
    end

    // buffer model and output comparison stepped once per edge
    always @(posedge sysclk) begin : compare
        logic wr_ok;
        logic rd_ok;
        if (arst_n_i) begin
            if (evt_valid_o) begin
                if (!rdy_d) begin
                    report_error("evt_valid_o high without out_rdy_i in the cycle before");
                end
                if (exp_dat_q.size() == 0) begin
                    report_error("output word arrived while none was expected");
                end
                check_value("evt_dat_o", evt_dat_o, exp_dat_q[0]);
                check_value("evt_last_o", evt_last_o, exp_last_q[0]);
                void'(exp_dat_q.pop_front());
                void'(exp_last_q.pop_front());
                out_cnt++;
            end else begin
                check_value("evt_last_o", evt_last_o, 1'b0);
            end
            check_value("fifo_full_o", fifo_full_o, occ == FIFO_DEPTH);
            check_value("fifo_empty_o", fifo_empty_o, occ == 0);
            if (u_dut.u_fifo.u_asserts.fail_cnt != 0) begin
                report_error("an assertion on the event buffer failed");
            end
            // writes at full are lost and pops need a stored word
            wr_ok = pend_valid && (occ < FIFO_DEPTH);
            rd_ok = out_rdy_i && (occ > 0);
            if (wr_ok) begin
                exp_dat_q.push_back(pend_word);
                exp_last_q.push_back(pend_last);
            end
            occ = occ + int'(wr_ok) - int'(rd_ok);
            rdy_d = out_rdy_i;
            if (complete_o) begin
                cmpl_cnt++;
            end
            if (fifo_full_o) begin
                full_seen = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        int out_start;
        arst_n_i = 1'b0;
        readout_i = 1'b0;
        readout_header_i = '0;
        doe_i = '0;
        out_rdy_i = 1'b1;
        rdy_mode = RDY_HIGH;
        pend_valid = 1'b0;
        pend_word = '0;
        pend_last = 1'b0;
        occ = 0;
        evt_num = 0;
        cmpl_cnt = 0;
        out_cnt = 0;
        full_seen = 1'b0;
        rdy_d = 1'b0;
        repeat (3) @(posedge sysclk);
        #5;
        arst_n_i = 1'b1;

        // reset state
        @(posedge sysclk);
        #5;
        check_value("evt_valid_o", evt_valid_o, 1'b0);
        check_value("evt_last_o", evt_last_o, 1'b0);
        check_value("complete_o", complete_o, 1'b0);
        check_value("fifo_full_o", fifo_full_o, 1'b0);
        check_value("fifo_empty_o", fifo_empty_o, 1'b1);

        // single event with downstream always ready
        run_event(1'b0);
        wait_drain();
        check_value("complete_o pulses", cmpl_cnt, evt_num);

        // back-to-back events wrap the counter in the header
        repeat (5) run_event(1'b0);
        wait_drain();
        check_value("complete_o pulses", cmpl_cnt, evt_num);

        // random back-pressure
        rdy_mode = RDY_RANDOM;
        repeat (3) run_event(1'b0);
        rdy_mode = RDY_HIGH;
        wait_drain();
        check_value("complete_o pulses", cmpl_cnt, evt_num);

        // overflow loses the third event
        rdy_mode = RDY_LOW;
        full_seen = 1'b0;
        repeat (3) run_event(1'b0);
        check_value("fifo_full_o seen", full_seen, 1'b1);
        out_start = out_cnt;
        rdy_mode = RDY_HIGH;
        wait_drain();
        check_value("words after overflow", out_cnt - out_start, FIFO_DEPTH);
        check_value("complete_o pulses", cmpl_cnt, evt_num);

        // strobe during readout is ignored and leaves the counter alone
        run_event(1'b1);
        wait_drain();
        run_event(1'b0);
        wait_drain();
        check_value("complete_o pulses", cmpl_cnt, evt_num);

        if (exp_dat_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_error("expected words never reached the output");
        end
    end

endmodule

//--- flist.f
logic/radiant_pkg.sv
logic/lab_wr_if.sv
logic/fifo_rd_if.sv
logic/lab_readout.sv
logic/event_fifo.sv
logic/event_sender.sv
logic/radiant_readout_top.sv
test/radiant_readout_asserts.sv
test/tb_radiant_readout.sv
